//--- src/sifh_hist_pkg.sv
package sifh_hist_pkg;

    // ==================================================
    // Code and bin geometry
    // ==================================================
    localparam int CODE_W      = 10;
    localparam int BIN_W       = 5;
    localparam int NUM_BINS    = 1 << BIN_W;
    localparam int MAX_COUNT_W = 24;

    typedef enum logic {
        MODE_COARSE = 1'b0,
        MODE_FINE   = 1'b1
    } hist_mode_e;

    // Frame sequencer states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_CLEAR = 3'd1,
        ST_ACCUM = 3'd2,
        ST_DRAIN = 3'd3,
        ST_SCAN  = 3'd4,
        ST_DONE  = 3'd5
    } hist_state_e;

    typedef struct packed {
        logic [BIN_W-1:0]       bin;
        logic [MAX_COUNT_W-1:0] count;
    } peak_t;

endpackage

//--- src/sifh_bus_pkg.sv
package sifh_bus_pkg;

    // ==================================================
    // Wishbone classic
    // ==================================================
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Detector timestamp with its own valid
    typedef struct packed {
        logic                             valid;
        logic [sifh_hist_pkg::CODE_W-1:0] code;
    } event_t;

    // ==================================================
    // Register map
    // ==================================================
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_STATUS   = 8'h01;
    localparam logic [7:0] REG_PEAK     = 8'h02;
    localparam logic [7:0] REG_COARSE   = 8'h03;
    localparam logic [7:0] REG_BIN_BASE = 8'h20;

endpackage

//--- src/hist_builder_fsm.sv
`timescale 1ns/1ps

module hist_builder_fsm #(
    parameter int EVENTS_PER_FRAME = 200
) (
    input  logic                              clk,
    input  logic                              res,
    input  logic                              start,
    input  sifh_hist_pkg::hist_mode_e         mode,
    input  logic [sifh_hist_pkg::BIN_W-1:0]   coarse_bin,
    input  sifh_bus_pkg::event_t              ev,
    output logic                              ev_ready,
    output sifh_hist_pkg::hist_state_e        state,
    output logic                              inc_en,
    output logic [sifh_hist_pkg::BIN_W-1:0]   inc_bin,
    output logic                              clr_en,
    output logic                              scan_en,
    output logic [sifh_hist_pkg::BIN_W-1:0]   addr_sweep
);

    localparam int EV_CNT_W = $clog2(EVENTS_PER_FRAME + 1);
    localparam int BIN_W    = sifh_hist_pkg::BIN_W;
    localparam int CODE_W   = sifh_hist_pkg::CODE_W;

    sifh_hist_pkg::hist_state_e state_next;
    logic [BIN_W:0]             sweep;
    logic [EV_CNT_W-1:0]        ev_cnt;
    logic                       accept;
    logic                       last_ev;
    logic                       hit;
    logic [BIN_W-1:0]           code_hi;
    logic [BIN_W-1:0]           code_lo;

    assign accept  = ev.valid && ev_ready;
    assign last_ev = ev_cnt == EV_CNT_W'(EVENTS_PER_FRAME - 1);

    // ==================================================
    // Code to bin mapping
    // ==================================================
    assign code_hi = ev.code[CODE_W-1 -: BIN_W];
    assign code_lo = ev.code[BIN_W-1:0];
    assign hit     = (mode == sifh_hist_pkg::MODE_COARSE) || (code_hi == coarse_bin);
    assign inc_en  = accept && hit;
    assign inc_bin = (mode == sifh_hist_pkg::MODE_COARSE) ? code_hi : code_lo;

    // Sweep shared by clear, drain and scan
    assign clr_en     = state == sifh_hist_pkg::ST_CLEAR;
    assign scan_en    = (state == sifh_hist_pkg::ST_SCAN) && !sweep[BIN_W];
    assign addr_sweep = sweep[BIN_W-1:0];

    always_comb begin
        state_next = state;
        case (state)
            sifh_hist_pkg::ST_IDLE,
            sifh_hist_pkg::ST_DONE:
                if (start) state_next = sifh_hist_pkg::ST_CLEAR;
            sifh_hist_pkg::ST_CLEAR:
                if (sweep == (BIN_W+1)'(sifh_hist_pkg::NUM_BINS - 1)) begin
                    state_next = sifh_hist_pkg::ST_ACCUM;
                end
            sifh_hist_pkg::ST_ACCUM:
                if (accept && last_ev) state_next = sifh_hist_pkg::ST_DRAIN;
            sifh_hist_pkg::ST_DRAIN:
                if (sweep == (BIN_W+1)'(1)) state_next = sifh_hist_pkg::ST_SCAN;
            // 32 reads plus the final compare
            sifh_hist_pkg::ST_SCAN:
                if (sweep[BIN_W]) state_next = sifh_hist_pkg::ST_DONE;
            default:
                state_next = sifh_hist_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= sifh_hist_pkg::ST_IDLE;
            ev_ready <= 1'b0;
            sweep    <= '0;
            ev_cnt   <= '0;
        end else begin
            state    <= state_next;
            ev_ready <= state_next == sifh_hist_pkg::ST_ACCUM;
            if (state_next != state) begin
                sweep <= '0;
            end else begin
                sweep <= sweep + 1'b1;
            end
            // Dropped fine-mode events still count toward the frame
            if (state == sifh_hist_pkg::ST_CLEAR) begin
                ev_cnt <= '0;
            end else if (accept) begin
                ev_cnt <= ev_cnt + 1'b1;
            end
        end
    end

    a_ready_in_accum: assert property (@(posedge clk) disable iff (!res)
        ev_ready |-> state == sifh_hist_pkg::ST_ACCUM);

endmodule

//--- src/hist_bin_ram.sv
`timescale 1ns/1ps

module hist_bin_ram #(
    parameter int COUNT_W = 16
) (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            inc_en,
    input  logic [sifh_hist_pkg::BIN_W-1:0] inc_bin,
    input  logic                            clr_en,
    input  logic [sifh_hist_pkg::BIN_W-1:0] clr_addr,
    input  logic                            rd_en,
    input  logic [sifh_hist_pkg::BIN_W-1:0] rd_addr,
    output logic [COUNT_W-1:0]              rd_data
);

    localparam int BIN_W = sifh_hist_pkg::BIN_W;

    logic [COUNT_W-1:0] mem [sifh_hist_pkg::NUM_BINS];

    logic               s1_valid;
    logic [BIN_W-1:0]   s1_bin;
    logic [COUNT_W-1:0] s1_data;
    logic               s2_valid;
    logic [BIN_W-1:0]   s2_bin;
    logic [COUNT_W-1:0] s2_data;
    logic [COUNT_W-1:0] cur;
    logic [COUNT_W-1:0] upd;

    // Stage 1 read is stale when the previous increment hit the same bin
    assign cur = (s2_valid && (s2_bin == s1_bin)) ? s2_data : s1_data;
    // Saturate at all ones
    assign upd = (&cur) ? cur : cur + 1'b1;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= inc_en;
            s2_valid <= s1_valid;
        end
    end

    // ==================================================
    // Memory and pipeline data
    // ==================================================
    always_ff @(posedge clk) begin
        s1_bin  <= inc_bin;
        s1_data <= mem[inc_bin];
        s2_bin  <= s1_bin;
        s2_data <= upd;
        if (s1_valid) begin
            mem[s1_bin] <= upd;
        end else if (clr_en) begin
            mem[clr_addr] <= '0;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Single write port, clear must not meet a new or in-flight increment
    a_clr_no_inc: assert property (@(posedge clk) disable iff (!res)
        clr_en |-> !inc_en && !s1_valid);

endmodule

//--- src/hist_peak_search.sv
`timescale 1ns/1ps

module hist_peak_search #(
    parameter int COUNT_W = 16
) (
    input  logic                            clk,
    input  logic                            res,
    input  logic                            scan_en,
    input  logic [sifh_hist_pkg::BIN_W-1:0] scan_addr,
    input  logic [COUNT_W-1:0]              scan_data,
    input  sifh_hist_pkg::hist_mode_e       mode,
    output sifh_hist_pkg::peak_t            peak,
    output logic [sifh_hist_pkg::BIN_W-1:0] coarse_bin
);

    localparam int BIN_W = sifh_hist_pkg::BIN_W;

    logic               cmp_en;
    logic [BIN_W-1:0]   cmp_bin;
    logic [COUNT_W-1:0] max_cnt;
    logic [BIN_W-1:0]   max_bin;
    logic               take;
    logic [COUNT_W-1:0] max_cnt_next;
    logic [BIN_W-1:0]   max_bin_next;

    // Bin 0 seeds the maximum, later bins need a strictly greater count
    assign take         = (cmp_bin == '0) || (scan_data > max_cnt);
    assign max_cnt_next = take ? scan_data : max_cnt;
    assign max_bin_next = take ? cmp_bin : max_bin;

    assign peak = '{bin: max_bin, count: sifh_hist_pkg::MAX_COUNT_W'(max_cnt)};

    // Address lines up with the registered RAM data
    always_ff @(posedge clk) begin
        cmp_bin <= scan_addr;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            cmp_en     <= 1'b0;
            max_cnt    <= '0;
            max_bin    <= '0;
            coarse_bin <= '0;
        end else begin
            cmp_en <= scan_en;
            if (cmp_en) begin
                max_cnt <= max_cnt_next;
                max_bin <= max_bin_next;
                if ((&cmp_bin) && (mode == sifh_hist_pkg::MODE_COARSE)) begin
                    coarse_bin <= max_bin_next;
                end
            end
        end
    end

endmodule

//--- src/hist_wb_regs.sv
`timescale 1ns/1ps

module hist_wb_regs #(
    parameter int COUNT_W = 16
) (
    input  logic                            clk,
    input  logic                            res,
    input  sifh_bus_pkg::wb_req_t           wb_req,
    output sifh_bus_pkg::wb_rsp_t           wb_rsp,
    input  sifh_hist_pkg::hist_state_e      state,
    input  sifh_hist_pkg::peak_t            peak,
    input  logic [sifh_hist_pkg::BIN_W-1:0] coarse_bin,
    input  logic [COUNT_W-1:0]              rd_data,
    output logic                            start,
    output sifh_hist_pkg::hist_mode_e       mode,
    output logic                            rd_en,
    output logic [sifh_hist_pkg::BIN_W-1:0] rd_addr
);

    logic        ack_q;
    logic [31:0] dat_q;
    logic        bin_pend;
    logic        bin_ok;
    logic [31:0] reg_rdata;
    logic        req_new;
    logic        is_bin;
    logic        bin_rd;
    logic        ctrl_wr;
    logic        busy;
    logic        done;

    assign busy = (state != sifh_hist_pkg::ST_IDLE) && (state != sifh_hist_pkg::ST_DONE);
    assign done = state == sifh_hist_pkg::ST_DONE;

    // A held request is seen once, not again while its ack is pending
    assign req_new = wb_req.cyc && wb_req.stb && !ack_q && !bin_pend;
    assign is_bin  = wb_req.adr[7:5] == sifh_bus_pkg::REG_BIN_BASE[7:5];
    assign bin_rd  = req_new && !wb_req.we && is_bin;
    assign ctrl_wr = req_new && wb_req.we && (wb_req.adr == sifh_bus_pkg::REG_CTRL);
    assign rd_en   = bin_rd && !busy;
    assign rd_addr = wb_req.adr[sifh_hist_pkg::BIN_W-1:0];

    always_comb begin
        case (wb_req.adr)
            sifh_bus_pkg::REG_STATUS: reg_rdata = {29'd0, mode, done, busy};
            sifh_bus_pkg::REG_PEAK:   reg_rdata = {3'd0, peak};
            sifh_bus_pkg::REG_COARSE: reg_rdata = {27'd0, coarse_bin};
            default:                  reg_rdata = '0;
        endcase
    end

    assign wb_rsp = '{ack: ack_q, dat: dat_q};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ack_q    <= 1'b0;
            bin_pend <= 1'b0;
            start    <= 1'b0;
            mode     <= sifh_hist_pkg::MODE_COARSE;
        end else begin
            start    <= ctrl_wr && wb_req.dat[0];
            bin_pend <= bin_rd;
            // Bin reads wait one extra cycle for the RAM
            ack_q    <= bin_pend || (req_new && !bin_rd);
            if (ctrl_wr && !busy) begin
                mode <= sifh_hist_pkg::hist_mode_e'(wb_req.dat[1]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_new) begin
            bin_ok <= rd_en;
        end
        if (bin_pend) begin
            dat_q <= bin_ok ? 32'(rd_data) : 32'd0;
        end else if (req_new) begin
            dat_q <= reg_rdata;
        end
    end

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (!res)
        ack_q |=> !ack_q);

endmodule

//--- src/sifh_hist_top.sv
`timescale 1ns/1ps

module sifh_hist_top #(
    parameter int EVENTS_PER_FRAME = 200,
    parameter int COUNT_W          = 16
) (
    input  logic                  clk,
    input  logic                  res,
    input  sifh_bus_pkg::wb_req_t wb_req,
    output sifh_bus_pkg::wb_rsp_t wb_rsp,
    input  sifh_bus_pkg::event_t  ev,
    output logic                  ev_ready
);

    localparam int BIN_W = sifh_hist_pkg::BIN_W;

    sifh_hist_pkg::hist_state_e state;
    sifh_hist_pkg::hist_mode_e  mode;
    sifh_hist_pkg::peak_t       peak;
    logic                       start;
    logic [BIN_W-1:0]           coarse_bin;
    logic                       inc_en;
    logic [BIN_W-1:0]           inc_bin;
    logic                       clr_en;
    logic                       scan_en;
    logic [BIN_W-1:0]           addr_sweep;
    logic                       wb_rd_en;
    logic [BIN_W-1:0]           wb_rd_addr;
    logic                       ram_rd_en;
    logic [BIN_W-1:0]           ram_rd_addr;
    logic [COUNT_W-1:0]         rd_data;

    if (COUNT_W > sifh_hist_pkg::MAX_COUNT_W) begin : g_count_w_check
        $error("COUNT_W is wider than MAX_COUNT_W");
    end

    // ==================================================
    // RAM read port owner
    // ==================================================
    assign ram_rd_en   = (state == sifh_hist_pkg::ST_SCAN) ? scan_en : wb_rd_en;
    assign ram_rd_addr = (state == sifh_hist_pkg::ST_SCAN) ? addr_sweep : wb_rd_addr;

    hist_builder_fsm #(
        .EVENTS_PER_FRAME (EVENTS_PER_FRAME)
    ) u_fsm (
        .clk        (clk),
        .res        (res),
        .start      (start),
        .mode       (mode),
        .coarse_bin (coarse_bin),
        .ev         (ev),
        .ev_ready   (ev_ready),
        .state      (state),
        .inc_en     (inc_en),
        .inc_bin    (inc_bin),
        .clr_en     (clr_en),
        .scan_en    (scan_en),
        .addr_sweep (addr_sweep)
    );

    hist_bin_ram #(
        .COUNT_W (COUNT_W)
    ) u_ram (
        .clk      (clk),
        .res      (res),
        .inc_en   (inc_en),
        .inc_bin  (inc_bin),
        .clr_en   (clr_en),
        .clr_addr (addr_sweep),
        .rd_en    (ram_rd_en),
        .rd_addr  (ram_rd_addr),
        .rd_data  (rd_data)
    );

    hist_peak_search #(
        .COUNT_W (COUNT_W)
    ) u_peak (
        .clk        (clk),
        .res        (res),
        .scan_en    (scan_en),
        .scan_addr  (addr_sweep),
        .scan_data  (rd_data),
        .mode       (mode),
        .peak       (peak),
        .coarse_bin (coarse_bin)
    );

    hist_wb_regs #(
        .COUNT_W (COUNT_W)
    ) u_regs (
        .clk        (clk),
        .res        (res),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .state      (state),
        .peak       (peak),
        .coarse_bin (coarse_bin),
        .rd_data    (rd_data),
        .start      (start),
        .mode       (mode),
        .rd_en      (wb_rd_en),
        .rd_addr    (wb_rd_addr)
    );

endmodule

//--- test/tb_sifh_hist.sv
`timescale 1ns/1ps

module tb_sifh_hist;

    // Three frames of at most 500 cycles, the bus reads, and margin
    localparam int CYCLE_LIMIT = 8000;
    localparam int FRAME_EVENTS = 200;

    logic                             clk;
    logic                             res;
    sifh_bus_pkg::wb_req_t            wb_req;
    sifh_bus_pkg::wb_rsp_t            wb_rsp;
    sifh_bus_pkg::event_t             ev;
    logic                             ev_ready;

    logic [31:0]                      lcg_state;
    int unsigned                      model_hist [32];
    sifh_hist_pkg::hist_mode_e        frame_mode;
    logic [4:0]                       frame_coarse;

    sifh_hist_top #(
        .EVENTS_PER_FRAME (FRAME_EVENTS),
        .COUNT_W          (16)
    ) UUT (
        .clk      (clk),
        .res      (res),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .ev       (ev),
        .ev_ready (ev_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic end_in_failure;
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR: %s expected 0x%0h actual 0x%0h", name, exp, act);
            end_in_failure();
        end
    endtask

    // ==================================================
    // Wishbone master
    // ==================================================
    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = 32'd0;
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);
        dat    = wb_rsp.dat;
        wb_req = '0;
    endtask

    // ==================================================
    // Event source and model histogram
    // ==================================================
    initial begin : event_source
        logic [31:0] r;
        logic [4:0]  hi;
        logic [4:0]  lo;
        logic        will_take;
        will_take = 1'b0;
        lcg_state = 32'h113d;
        ev        = '0;
        @(posedge res);
        forever begin
            @(negedge clk);
            if (will_take) begin
                hi = ev.code[9:5];
                lo = ev.code[4:0];
                if (frame_mode == sifh_hist_pkg::MODE_COARSE) begin
                    model_hist[hi]++;
                end else if (hi == frame_coarse) begin
                    model_hist[lo]++;
                end
            end
            // Hold an offered event until it is taken
            if (will_take || !ev.valid) begin
                lcg_state = lcg_next(lcg_state);
                r         = lcg_state;
                ev.valid  = r[31:30] != 2'b00;
                if (r[29:28] == 2'b00) begin
                    // Cluster around one coarse bin, partly narrowed in the fine window
                    ev.code = {5'd19, r[27] ? {2'b01, r[18:16]} : r[20:16]};
                end else begin
                    ev.code = r[25:16];
                end
            end
            // ev_ready holds until the next rising edge
            will_take = ev.valid && ev_ready;
        end
    end

    task automatic run_frame(input sifh_hist_pkg::hist_mode_e m, input bit try_restart);
        logic [31:0] st;
        int          k;
        for (k = 0; k < 32; k++) begin
            model_hist[k] = 0;
        end
        frame_mode = m;
        wb_write(sifh_bus_pkg::REG_CTRL, {30'd0, m, 1'b1});
        do begin
            wb_read(sifh_bus_pkg::REG_STATUS, st);
        end while (!st[0]);
        if (try_restart) begin
            // Second start lands in the middle of accumulation
            while (!ev_ready) begin
                @(negedge clk);
            end
            repeat (20) @(negedge clk);
            wb_write(sifh_bus_pkg::REG_CTRL, {30'd0, m, 1'b1});
        end
        do begin
            wb_read(sifh_bus_pkg::REG_STATUS, st);
        end while (!st[1]);
        check_value("status at done", {29'd0, m, 2'b10}, st);
        // A second start must not have queued another frame
        repeat (4) @(negedge clk);
        wb_read(sifh_bus_pkg::REG_STATUS, st);
        check_value("status after done", {29'd0, m, 2'b10}, st);
    endtask

    task automatic check_bins(input string name, input bit check_total);
        logic [31:0] v;
        int unsigned sum;
        int          k;
        sum = 0;
        for (k = 0; k < 32; k++) begin
            wb_read(sifh_bus_pkg::REG_BIN_BASE + 8'(k), v);
            check_value($sformatf("%s bin %0d", name, k), model_hist[k], v);
            sum += v;
        end
        if (check_total) begin
            check_value({name, " total"}, FRAME_EVENTS, sum);
        end
    endtask

    task automatic check_peak(input string name, input bit coarse);
        logic [31:0] v;
        int          best;
        int          k;
        best = 0;
        // Lowest bin wins a tie
        for (k = 1; k < 32; k++) begin
            if (model_hist[k] > model_hist[best]) best = k;
        end
        wb_read(sifh_bus_pkg::REG_PEAK, v);
        check_value({name, " peak"}, {3'd0, 5'(best), 24'(model_hist[best])}, v);
        if (coarse) frame_coarse = 5'(best);
        wb_read(sifh_bus_pkg::REG_COARSE, v);
        check_value({name, " coarse bin"}, {27'd0, frame_coarse}, v);
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= CYCLE_LIMIT) begin
                $display("Timeout: the frames did not finish within %0d cycles", cycles);
                end_in_failure();
            end
        end
    end

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin : main
        logic [31:0] v;
        res          = 1'b0;
        wb_req       = '0;
        frame_mode   = sifh_hist_pkg::MODE_COARSE;
        frame_coarse = 5'd0;
        repeat (16) @(negedge clk);
        res = 1'b1;

        @(negedge clk);
        check_value("reset ev_ready", 32'd0, {31'd0, ev_ready});
        wb_read(sifh_bus_pkg::REG_STATUS, v);
        check_value("reset status", 32'd0, v);
        wb_read(sifh_bus_pkg::REG_COARSE, v);
        check_value("reset coarse bin", 32'd0, v);

        run_frame(sifh_hist_pkg::MODE_COARSE, 1'b0);
        check_bins("coarse frame", 1'b1);
        check_peak("coarse frame", 1'b1);

        // Window is the coarse peak just found
        run_frame(sifh_hist_pkg::MODE_FINE, 1'b0);
        check_bins("fine frame", 1'b0);
        check_peak("fine frame", 1'b0);

        run_frame(sifh_hist_pkg::MODE_COARSE, 1'b1);
        check_bins("second coarse frame", 1'b1);
        check_peak("second coarse frame", 1'b1);

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- sim.f
src/sifh_hist_pkg.sv
src/sifh_bus_pkg.sv
src/hist_builder_fsm.sv
src/hist_bin_ram.sv
src/hist_peak_search.sv
src/hist_wb_regs.sv
src/sifh_hist_top.sv
test/tb_sifh_hist.sv

//--- Bender.yml
package:
  name: sifh_hist

sources:
  - src/sifh_hist_pkg.sv
  - src/sifh_bus_pkg.sv
  - src/hist_builder_fsm.sv
  - src/hist_bin_ram.sv
  - src/hist_peak_search.sv
  - src/hist_wb_regs.sv
  - src/sifh_hist_top.sv
  - target: test
    files:
      - test/tb_sifh_hist.sv
